//--- Bender.yml
package:
  name: uart_echo

sources:
  - files:
      - design/uart_pkg.sv
      - design/uart_rx.sv
      - design/uart_tx.sv
      - design/uart_echo_top.sv

  - target: simulation
    files:
      - verification/uart_clock_gen.sv
      - verification/uart_echo_tb.sv

//--- design/uart_echo_top.sv
`timescale 1ns/10ps

module uart_echo_top (
    input  logic clk,
    input  logic reset,
    input  logic uart_rxd,
    output logic uart_txd,
    output logic led
);
    import uart_pkg::*;

    uart_rx_frame_t       rx_frame;         // From receiver
    uart_tx_req_t         tx_req;           // To transmitter
    logic                 tx_busy;
    logic                 start_q;
    logic [data_bits-1:0] data_q;           // Echo byte, no reset
    logic                 led_q;

    ////////////////////////////////////////
    // UART halves
    ////////////////////////////////////////

    uart_rx u_rx (
        .clk      (clk),
        .reset    (reset),
        .rxd      (uart_rxd),
        .rx_frame (rx_frame)
    );

    uart_tx u_tx (
        .clk     (clk),
        .reset   (reset),
        .tx_req  (tx_req),
        .txd     (uart_txd),
        .tx_busy (tx_busy)
    );

    ////////////////////////////////////////
    // Echo decision
    ////////////////////////////////////////

    // Good byte and idle transmitter, else dropped
    wire accept = rx_frame.valid & ~rx_frame.frame_error & ~tx_busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            start_q <= 1'b0;
            led_q   <= 1'b0;
        end else begin
            start_q <= accept;              // One-cycle request
            if (accept)
                led_q <= ~led_q;            // Toggle per echoed byte
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            data_q <= rx_frame.data;
    end

    assign tx_req = '{start: start_q, data: data_q};
    assign led    = led_q;

    // LED only moves on an accepted frame
    a_led_on_echo: assert property (@(posedge clk) disable iff (reset)
        !$stable(led) |-> $past(accept));

endmodule

//--- design/uart_pkg.sv
package uart_pkg;

    ////////////////////////////////////////
    // Line timing
    ////////////////////////////////////////

    // Clock cycles per bit, 625 kbaud at 10 MHz
    localparam int clks_per_bit = 16;

    // Falling start edge to mid-bit sample
    localparam int half_bit = 8;

    localparam int data_bits = 8;           // 8N1 only

    // Counter widths
    localparam int cnt_w = $clog2(clks_per_bit);
    localparam int idx_w = $clog2(data_bits);

    ////////////////////////////////////////
    // Shared types
    ////////////////////////////////////////

    // Line state, same encoding on both sides
    typedef enum logic [1:0] {
        IDLE,                               // Line high, waiting
        START,                              // Start bit
        DATA,                               // 8 data bits, LSB first
        STOP                                // Stop bit
    } uart_state_e;

    // Receiver to top, 10 bits
    typedef struct packed {
        logic                 valid;        // One cycle per frame
        logic                 frame_error;  // Stop bit was low
        logic [data_bits-1:0] data;
    } uart_rx_frame_t;

    // Top to transmitter, 9 bits
    typedef struct packed {
        logic                 start;        // One-cycle request
        logic [data_bits-1:0] data;         // Taken with start
    } uart_tx_req_t;

endpackage

//--- design/uart_rx.sv
`timescale 1ns/10ps

module uart_rx (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     rxd,
    output uart_pkg::uart_rx_frame_t rx_frame
);
    import uart_pkg::*;

    ////////////////////////////////////////
    // Input synchronizer
    ////////////////////////////////////////

    logic rxd_meta;                         // First stage
    logic rxd_sync;                         // Safe to use
    logic rxd_prev;                         // For edge detect

    always_ff @(posedge clk) begin
        if (reset) begin
            rxd_meta <= 1'b1;               // Idle line is high
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    wire start_edge = rxd_prev & ~rxd_sync;

    ////////////////////////////////////////
    // Receive FSM
    ////////////////////////////////////////

    uart_state_e          state;
    logic [cnt_w-1:0]     cnt;              // Cycles within the bit
    logic [idx_w-1:0]     idx;              // Data bit index
    logic [data_bits-1:0] shift_q;          // Payload, no reset
    logic                 valid_q;
    logic                 ferr_q;

    wire bit_end  = (cnt == cnt_w'(clks_per_bit - 1));
    wire half_end = (cnt == cnt_w'(half_bit - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= IDLE;
            cnt     <= '0;
            idx     <= '0;
            valid_q <= 1'b0;
            ferr_q  <= 1'b0;
        end else begin
            valid_q <= 1'b0;                // Strobe by default
            cnt     <= cnt + 1'b1;
            case (state)
                IDLE: begin
                    cnt <= '0;
                    if (start_edge)
                        state <= START;
                end
                START: if (half_end) begin
                    cnt <= '0;
                    idx <= '0;
                    // Line back high at mid-bit, treat as glitch
                    state <= rxd_sync ? IDLE : DATA;
                end
                DATA: if (bit_end) begin
                    cnt <= '0;
                    idx <= idx + 1'b1;
                    if (idx == idx_w'(data_bits - 1))
                        state <= STOP;
                end
                STOP: if (bit_end) begin
                    state   <= IDLE;        // Mid stop bit, line settles
                    valid_q <= 1'b1;
                    ferr_q  <= ~rxd_sync;   // Low stop bit
                end
                default: state <= IDLE;
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clk) begin
        if (state == DATA && bit_end)
            shift_q <= {rxd_sync, shift_q[data_bits-1:1]};
    end

    assign rx_frame = '{valid: valid_q, frame_error: ferr_q, data: shift_q};

    // Frames are a whole bit period apart at least
    a_valid_single: assert property (@(posedge clk) disable iff (reset)
        rx_frame.valid |=> !rx_frame.valid);

endmodule

//--- design/uart_tx.sv
`timescale 1ns/10ps

module uart_tx (
    input  logic                   clk,
    input  logic                   reset,
    input  uart_pkg::uart_tx_req_t tx_req,
    output logic                   txd,
    output logic                   tx_busy
);
    import uart_pkg::*;

    ////////////////////////////////////////
    // Transmit FSM
    ////////////////////////////////////////

    uart_state_e          state;
    logic [cnt_w-1:0]     cnt;              // Cycles within the bit
    logic [idx_w-1:0]     idx;              // Data bit index
    logic [data_bits-1:0] shift_q;          // Remaining data bits
    logic                 txd_q;            // Registered line driver

    wire bit_end = (cnt == cnt_w'(clks_per_bit - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            cnt   <= '0;
            idx   <= '0;
            txd_q <= 1'b1;                  // Line idles high
        end else begin
            cnt <= cnt + 1'b1;
            case (state)
                IDLE: begin
                    cnt <= '0;
                    // Start only seen here, busy requests are ignored
                    if (tx_req.start) begin
                        state <= START;
                        txd_q <= 1'b0;      // Start bit next cycle
                    end
                end
                START: if (bit_end) begin
                    state <= DATA;
                    cnt   <= '0;
                    idx   <= '0;
                    txd_q <= shift_q[0];    // Bit 0 first
                end
                DATA: if (bit_end) begin
                    cnt <= '0;
                    idx <= idx + 1'b1;
                    if (idx == idx_w'(data_bits - 1)) begin
                        state <= STOP;
                        txd_q <= 1'b1;      // Stop bit
                    end else begin
                        txd_q <= shift_q[1];
                    end
                end
                STOP: if (bit_end)
                    state <= IDLE;          // txd stays high
                default: state <= IDLE;
            endcase
        end
    end

    // Payload shifter, no reset needed
    always_ff @(posedge clk) begin
        if (state == IDLE && tx_req.start)
            shift_q <= tx_req.data;
        else if (state == DATA && bit_end)
            shift_q <= shift_q >> 1;
    end

    assign txd     = txd_q;
    assign tx_busy = (state != IDLE);      // Covers start to end of stop

    a_idle_high: assert property (@(posedge clk) disable iff (reset)
        state == IDLE |-> txd);

    // Requester must honour busy
    a_no_start_busy: assert property (@(posedge clk) disable iff (reset)
        tx_req.start |-> !tx_busy);

endmodule

//--- sim.f
design/uart_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/uart_echo_top.sv
verification/uart_clock_gen.sv
verification/uart_echo_tb.sv

//--- verification/uart_clock_gen.sv
`timescale 1ns/10ps

module uart_clock_gen (
    output logic clk,
    output logic reset
);
    localparam time half_period  = 50ns;    // 100 ns clock, 10 MHz
    localparam int  reset_cycles = 5;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // Synchronous reset, released on a rising edge
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- verification/uart_echo_tb.sv
`timescale 1ns/10ps

module uart_echo_tb;
    import uart_pkg::*;

    ////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////

    typedef struct packed {
        logic [data_bits-1:0] data;
        logic                 stop;         // Stop bit level on the line
        logic                 short_start;  // Glitch row without a full frame
        logic                 echo;         // Echo expected on uart_txd
    } row_t;

    localparam int num_rows      = 10;
    localparam int glitch_cycles = 4;       // Well under half_bit
    localparam int echo_timeout  = 30 * clks_per_bit;
    localparam int reset_timeout = 20;
    localparam int frame_cycles  = (data_bits + 2) * clks_per_bit;

    logic   clk;
    logic   reset;
    logic   uart_rxd;
    logic   uart_txd;
    logic   led;
    row_t   stim_table [num_rows];
    integer seed = 56032;
    int     echoed;                         // Bytes echoed so far

    uart_clock_gen i_clk_gen (
        .clk   (clk),
        .reset (reset)
    );

    uart_echo_top i_dut (
        .clk      (clk),
        .reset    (reset),
        .uart_rxd (uart_rxd),
        .uart_txd (uart_txd),
        .led      (led)
    );

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        if (got !== exp)
            stop_on_error($sformatf("FAILED at %0t: %s got 0x%0h expected 0x%0h",
                                    $time, name, got, exp));
    endtask

    // Expected line level for bit k of an 8N1 frame
    function automatic logic frame_bit(input logic [data_bits-1:0] data, input int k);
        if (k == 0)
            return 1'b0;
        if (k == data_bits + 1)
            return 1'b1;
        return data[k-1];
    endfunction

    task automatic fill_table();
        stim_table[0] = '{data: 8'h00, stop: 1'b1, short_start: 1'b0, echo: 1'b1};
        stim_table[1] = '{data: 8'hFF, stop: 1'b1, short_start: 1'b0, echo: 1'b1};
        stim_table[2] = '{data: 8'h55, stop: 1'b1, short_start: 1'b0, echo: 1'b1};
        stim_table[3] = '{data: 8'hA3, stop: 1'b1, short_start: 1'b0, echo: 1'b1};
        stim_table[4] = '{data: 8'h3C, stop: 1'b0, short_start: 1'b0, echo: 1'b0};
        stim_table[5] = '{data: 8'h00, stop: 1'b1, short_start: 1'b1, echo: 1'b0};
        for (int i = 6; i < num_rows; i++) begin
            stim_table[i].data        = 8'($random(seed));
            stim_table[i].stop        = 1'b1;
            stim_table[i].short_start = 1'b0;
            stim_table[i].echo        = 1'b1;
        end
    endtask

    ////////////////////////////////////////
    // Serial driver and monitor
    ////////////////////////////////////////

    task automatic send_bit(input logic b);
        @(posedge clk);
        uart_rxd <= b;
        repeat (clks_per_bit - 1) @(posedge clk); // Hold one bit period
    endtask

    task automatic drive_frame(input row_t row);
        if (row.short_start) begin
            @(posedge clk);
            uart_rxd <= 1'b0;               // Start pulse too short
            repeat (glitch_cycles) @(posedge clk);
            uart_rxd <= 1'b1;
        end else begin
            send_bit(1'b0);
            for (int i = 0; i < data_bits; i++)
                send_bit(row.data[i]);      // LSB first
            send_bit(row.stop);
            @(posedge clk);
            uart_rxd <= 1'b1;               // Back to idle
        end
    endtask

    // Samples on the falling edge away from DUT updates
    task automatic watch_echo(input int r);
        row_t row;
        int   waited;
        bit   seen;
        int   k;
        int   pos;
        row    = stim_table[r];
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < echo_timeout) begin
            @(negedge clk);
            waited++;
            if (uart_txd === 1'b0)
                seen = 1'b1;                // First low sample of start bit
        end
        if (seen && !row.echo)
            stop_on_error($sformatf("unexpected start bit on uart_txd for row %0d", r));
        if (!seen && row.echo)
            stop_on_error($sformatf("no echo on uart_txd within timeout for row %0d", r));
        if (seen) begin
            // Near both ends and the middle of every bit
            for (int s = 1; s < frame_cycles; s++) begin
                @(negedge clk);
                k   = s / clks_per_bit;
                pos = s % clks_per_bit;
                if (pos == 1 || pos == half_bit || pos == clks_per_bit - 2)
                    check_value($sformatf("uart_txd bit %0d", k), uart_txd,
                                frame_bit(row.data, k));
            end
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        int waited;
        uart_rxd = 1'b1;                    // Idle line
        echoed   = 0;
        waited   = 0;
        fill_table();
        while (reset !== 1'b0) begin
            @(negedge clk);
            waited++;
            if (waited > reset_timeout)
                stop_on_error("reset was never released");
        end
        @(negedge clk);
        check_value("uart_txd", uart_txd, 8'd1);
        check_value("led", led, 8'd0);

        for (int r = 0; r < num_rows; r++) begin
            fork
                drive_frame(stim_table[r]);
                watch_echo(r);
            join
            if (stim_table[r].echo)
                echoed++;
            check_value("led", led, 8'(echoed % 2)); // One toggle per echo
            repeat (clks_per_bit) @(negedge clk);   // Idle gap between rows
        end

        $display("all tests passed");
        $finish;
    end

endmodule
